/* source/rename_pkg.sv */
`default_nettype none

package rename_pkg;

	// Register file sizes
	localparam int arch_regs = 32;
	localparam int phys_regs = 64;

	// Tags not held by the architectural map sit in the free list
	localparam int free_depth = phys_regs - arch_regs;

	typedef logic [$clog2(arch_regs)-1:0] arch_reg_t;
	typedef logic [$clog2(phys_regs)-1:0] phys_tag_t;

	// Result of a rename, handed to the dispatcher and the ROB
	typedef struct packed {
		phys_tag_t t_new; // Freshly allocated tag
		phys_tag_t t_old; // Previous mapping of the destination
	} rename_t;

	// Instruction leaving the ROB head
	typedef struct packed {
		arch_reg_t dest;
		phys_tag_t t_new; // Goes into the architectural map
		phys_tag_t t_old; // Goes back to the free list
	} retire_t;

	// One ROB row
	typedef struct packed {
		logic      busy;
		logic      done;
		arch_reg_t dest;
		phys_tag_t t_new;
		phys_tag_t t_old;
	} rob_entry_t;

endpackage

`default_nettype wire

/* source/free_list.sv */
`default_nettype none
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
	input  logic      clock,
	input  logic      rst,
	input  logic      alloc_en,
	input  logic      retire_valid,
	input  retire_t   retire,
	input  logic      flush,
	output phys_tag_t alloc_tag,
	output logic      free_empty,
	output logic [5:0] free_count
);

	// Index bits plus one wrap bit
	localparam int ptr_w = $clog2(free_depth) + 1;

	phys_tag_t tag_q [free_depth];

	logic [ptr_w-1:0] spec_head; // Next tag handed out
	logic [ptr_w-1:0] ret_head;  // Position of the last retired allocation
	logic [ptr_w-1:0] tail;      // Where returned tags are written

	assign alloc_tag  = tag_q[spec_head[ptr_w-2:0]];
	assign free_empty = (tail == spec_head);
	assign free_count = tail - spec_head;

	always_ff @(posedge clock) begin
		if (rst) begin
			// Tags above the architectural range start out free
			for (int i = 0; i < free_depth; i++) begin
				tag_q[i] <= phys_tag_t'(arch_regs + i);
			end
			spec_head <= '0;
			ret_head  <= '0;
			tail      <= ptr_w'(free_depth); // Full since the wrap bits differ
		end else begin
			if (flush) begin
				// Squashed allocations become free again
				spec_head <= ret_head;
			end else if (alloc_en) begin
				spec_head <= spec_head + 1'b1;
			end

			if (retire_valid) begin
				tag_q[tail[ptr_w-2:0]] <= retire.t_old;
				tail     <= tail + 1'b1;
				ret_head <= ret_head + 1'b1; // Its allocation is now permanent
			end
		end
	end

	// Dispatcher must hold off while the list is empty
	a_no_alloc_when_empty: assert property (
		@(posedge clock) disable iff (rst)
		alloc_en |-> !free_empty
	) else $error("free list allocate while empty");

	// A retire always follows an allocation that is still outstanding
	a_retire_has_alloc: assert property (
		@(posedge clock) disable iff (rst)
		retire_valid |-> (ret_head != spec_head)
	) else $error("free list retire without outstanding allocation");

	// Returned tags never overrun the list
	a_count_bound: assert property (
		@(posedge clock) disable iff (rst)
		free_count <= ptr_w'(free_depth)
	) else $error("free list count above capacity");

endmodule

`default_nettype wire

/* source/map_table.sv */
`default_nettype none
`timescale 1ns/1ps

module map_table import rename_pkg::*; (
	input  logic      clock,
	input  logic      rst,
	input  logic      dispatch_en,
	input  arch_reg_t dispatch_dest,
	input  phys_tag_t alloc_tag,
	input  logic      retire_valid,
	input  retire_t   retire,
	input  logic      flush,
	output phys_tag_t old_tag
);

	phys_tag_t spec_map [arch_regs]; // Front end view, updated at dispatch
	phys_tag_t arch_map [arch_regs]; // Committed view, updated at retire

	// Current mapping of the destination becomes t_old
	assign old_tag = spec_map[dispatch_dest];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < arch_regs; i++) begin
				spec_map[i] <= phys_tag_t'(i);
			end
		end else if (flush) begin
			// Roll back to the committed state
			spec_map <= arch_map;
		end else if (dispatch_en) begin
			spec_map[dispatch_dest] <= alloc_tag;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < arch_regs; i++) begin
				arch_map[i] <= phys_tag_t'(i); // Identity map out of reset
			end
		end else if (retire_valid) begin
			arch_map[retire.dest] <= retire.t_new;
		end
	end

	// No instruction is renamed in the cycle its branch is squashed
	a_no_dispatch_on_flush: assert property (
		@(posedge clock) disable iff (rst)
		!(dispatch_en && flush)
	) else $error("map table dispatch during flush");

endmodule

`default_nettype wire

/* source/reorder_buffer.sv */
`default_nettype none
`timescale 1ns/1ps

module reorder_buffer import rename_pkg::*; #(
	parameter int rob_depth = 16
) (
	input  logic      clock,
	input  logic      rst,
	input  logic      dispatch_en,
	input  arch_reg_t dispatch_dest,
	input  rename_t   rename,
	input  logic      cdb_valid,
	input  phys_tag_t cdb_tag,
	input  logic      flush,
	output logic      retire_valid,
	output retire_t   retire,
	output logic      rob_full,
	output logic [$clog2(rob_depth):0] rob_free_entries
);

	localparam int ptr_w = $clog2(rob_depth);
	localparam int cnt_w = ptr_w + 1;

	rob_entry_t rob_q [rob_depth];

	logic [ptr_w-1:0] head; // Oldest instruction
	logic [ptr_w-1:0] tail; // Next free row
	logic [cnt_w-1:0] count;

	logic [rob_depth-1:0] cdb_hit;  // Tag match over all rows
	logic [rob_depth-1:0] done_vec;

	rob_entry_t head_entry;

	assign head_entry = rob_q[head];

	// Completion tag match
	always_comb begin
		for (int i = 0; i < rob_depth; i++) begin
			cdb_hit[i]  = cdb_valid && rob_q[i].busy && (rob_q[i].t_new == cdb_tag);
			done_vec[i] = rob_q[i].done;
		end
	end

	// Head leaves once it is finished, unless the branch squashes it
	assign retire_valid = head_entry.busy && head_entry.done && !flush;

	assign retire = '{
		dest:  head_entry.dest,
		t_new: head_entry.t_new,
		t_old: head_entry.t_old
	};

	assign rob_full         = (count == cnt_w'(rob_depth));
	assign rob_free_entries = cnt_w'(rob_depth) - count;

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			for (int i = 0; i < rob_depth; i++) begin
				rob_q[i].busy <= 1'b0;
				rob_q[i].done <= 1'b0;
			end
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			for (int i = 0; i < rob_depth; i++) begin
				if (cdb_hit[i]) begin
					rob_q[i].done <= 1'b1;
				end
			end

			if (retire_valid) begin
				rob_q[head].busy <= 1'b0;
				rob_q[head].done <= 1'b0;
				head <= head + 1'b1;
			end

			// Tail row is never busy, so no clash with the match above
			if (dispatch_en) begin
				rob_q[tail] <= '{
					busy:  1'b1,
					done:  1'b0,
					dest:  dispatch_dest,
					t_new: rename.t_new,
					t_old: rename.t_old
				};
				tail <= tail + 1'b1;
			end

			case ({dispatch_en, retire_valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	// Dispatcher honours dispatch_ready
	a_no_dispatch_when_full: assert property (
		@(posedge clock) disable iff (rst)
		dispatch_en |-> !rob_full
	) else $error("ROB dispatch while full");

	// Physical tags in flight are unique
	a_single_hit: assert property (
		@(posedge clock) disable iff (rst)
		cdb_valid |-> $onehot0(cdb_hit)
	) else $error("ROB completion tag matches more than one entry");

	// Each instruction completes once
	a_no_double_done: assert property (
		@(posedge clock) disable iff (rst)
		cdb_valid |-> ((cdb_hit & done_vec) == '0)
	) else $error("ROB completion on an entry already done");

endmodule

`default_nettype wire

/* source/rename_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module rename_unit import rename_pkg::*; #(
	parameter int rob_depth = 16
) (
	input  logic      clock,
	input  logic      rst,
	input  logic      dispatch_en,
	input  arch_reg_t dispatch_dest,
	input  logic      cdb_valid,
	input  phys_tag_t cdb_tag,
	input  logic      flush,
	output rename_t   rename,
	output logic      dispatch_ready,
	output logic      retire_valid,
	output retire_t   retire,
	output logic [$clog2(rob_depth):0] rob_free_entries,
	output logic [5:0] free_count
);

	phys_tag_t alloc_tag;
	phys_tag_t old_tag;
	logic      free_empty;
	logic      rob_full;

	// Same rename goes to the dispatcher and into the ROB
	assign rename = '{t_new: alloc_tag, t_old: old_tag};

	// Room in both the ROB and the free list
	assign dispatch_ready = !rob_full && !free_empty;

	free_list u_free_list (
		.clock        (clock),
		.rst          (rst),
		.alloc_en     (dispatch_en),
		.retire_valid (retire_valid),
		.retire       (retire),
		.flush        (flush),
		.alloc_tag    (alloc_tag),
		.free_empty   (free_empty),
		.free_count   (free_count)
	);

	map_table u_map_table (
		.clock         (clock),
		.rst           (rst),
		.dispatch_en   (dispatch_en),
		.dispatch_dest (dispatch_dest),
		.alloc_tag     (alloc_tag),
		.retire_valid  (retire_valid),
		.retire        (retire),
		.flush         (flush),
		.old_tag       (old_tag)
	);

	reorder_buffer #(
		.rob_depth (rob_depth)
	) u_reorder_buffer (
		.clock            (clock),
		.rst              (rst),
		.dispatch_en      (dispatch_en),
		.dispatch_dest    (dispatch_dest),
		.rename           (rename),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.flush            (flush),
		.retire_valid     (retire_valid),
		.retire           (retire),
		.rob_full         (rob_full),
		.rob_free_entries (rob_free_entries)
	);

endmodule

`default_nettype wire

/* dv/rename_vectors.svh */
`ifndef rename_vectors_svh
`define rename_vectors_svh

// Each row holds a kind, an architectural register and the dispatch that a completion names
// Dispatches are numbered from zero in table order

localparam int n_vectors = 33;

localparam vector_t vectors [n_vectors] = '{
	'{k_dispatch, 5'd3, 8'd0},  // Seq 0 gets t_old 3
	'{k_dispatch, 5'd7, 8'd0},  // Seq 1 gets t_old 7
	'{k_dispatch, 5'd3, 8'd0},  // Seq 2 sees seq 0 as t_old
	'{k_complete, 5'd0, 8'd2},  // Youngest finishes first
	'{k_idle,     5'd0, 8'd0},
	'{k_complete, 5'd0, 8'd0},
	'{k_idle,     5'd0, 8'd0},  // Seq 0 retires
	'{k_complete, 5'd0, 8'd1},
	'{k_idle,     5'd0, 8'd0},  // Seq 1 retires
	'{k_idle,     5'd0, 8'd0},  // Seq 2 retires
	// Fill the ROB with no completions
	'{k_dispatch, 5'd1, 8'd0},  // Seq 3
	'{k_dispatch, 5'd2, 8'd0},
	'{k_dispatch, 5'd3, 8'd0},
	'{k_dispatch, 5'd4, 8'd0},
	'{k_dispatch, 5'd5, 8'd0},
	'{k_dispatch, 5'd6, 8'd0},
	'{k_dispatch, 5'd7, 8'd0},
	'{k_dispatch, 5'd8, 8'd0},
	'{k_dispatch, 5'd9, 8'd0},
	'{k_dispatch, 5'd10, 8'd0},
	'{k_dispatch, 5'd11, 8'd0},
	'{k_dispatch, 5'd12, 8'd0},
	'{k_dispatch, 5'd13, 8'd0},
	'{k_dispatch, 5'd14, 8'd0},
	'{k_dispatch, 5'd15, 8'd0},
	'{k_dispatch, 5'd16, 8'd0}, // Seq 18 fills the ROB
	'{k_idle,     5'd0, 8'd0},  // dispatch_ready low here
	'{k_complete, 5'd0, 8'd3},  // Oldest entry
	'{k_idle,     5'd0, 8'd0},  // Its retire frees one row
	'{k_flush,    5'd0, 8'd0},  // Squash seq 4 to 18
	'{k_dispatch, 5'd1, 8'd0},  // t_old is the retired tag of seq 3
	'{k_dispatch, 5'd3, 8'd0},  // t_old is the retired tag of seq 2
	'{k_idle,     5'd0, 8'd0}
};

`endif

/* dv/rename_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

	localparam int rob_depth = 16;
	localparam int n_random  = 400;

	localparam logic [1:0] k_idle     = 2'd0;
	localparam logic [1:0] k_dispatch = 2'd1;
	localparam logic [1:0] k_complete = 2'd2;
	localparam logic [1:0] k_flush    = 2'd3;

	typedef struct packed {
		logic [1:0] kind;
		arch_reg_t  dest;
		logic [7:0] seq; // Earlier dispatch named by a completion
	} vector_t;

	typedef struct packed {
		logic      done;
		arch_reg_t dest;
		phys_tag_t t_new;
		phys_tag_t t_old;
	} model_entry_t;

	`include "rename_vectors.svh"

	logic      clock;
	logic      rst;
	logic      dispatch_en;
	arch_reg_t dispatch_dest;
	logic      cdb_valid;
	phys_tag_t cdb_tag;
	logic      flush;
	rename_t   rename;
	logic      dispatch_ready;
	logic      retire_valid;
	retire_t   retire;
	logic [$clog2(rob_depth):0] rob_free_entries;
	logic [5:0] free_count;

	phys_tag_t    spec_m [arch_regs]; // Reference model state
	phys_tag_t    arch_m [arch_regs];
	phys_tag_t    free_m [$];         // Front is the next tag handed out
	model_entry_t rob_m [$];          // Front is the oldest instruction

	phys_tag_t   seq_tag [64];
	phys_tag_t   last_new;
	logic [15:0] lfsr;
	int          errors;
	int          checks;

	rename_unit #(
		.rob_depth (rob_depth)
	) dut (
		.clock            (clock),
		.rst              (rst),
		.dispatch_en      (dispatch_en),
		.dispatch_dest    (dispatch_dest),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.flush            (flush),
		.rename           (rename),
		.dispatch_ready   (dispatch_ready),
		.retire_valid     (retire_valid),
		.retire           (retire),
		.rob_free_entries (rob_free_entries),
		.free_count       (free_count)
	);

	always #5 clock = ~clock;

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic logic [7:0] lfsr_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	task automatic model_reset();
		free_m.delete();
		rob_m.delete();
		for (int i = 0; i < arch_regs; i++) begin
			spec_m[i] = phys_tag_t'(i);
			arch_m[i] = phys_tag_t'(i);
		end
		for (int i = arch_regs; i < phys_regs; i++) begin
			free_m.push_back(phys_tag_t'(i));
		end
	endtask

	// Drives one cycle, checks mid cycle and then advances the model past the edge
	task automatic run_cycle(input logic [1:0] kind, input arch_reg_t dest, input phys_tag_t tag);
		logic         exp_retire;
		phys_tag_t    exp_new;
		phys_tag_t    exp_old;
		model_entry_t head;
		@(posedge clock);
		#1;
		dispatch_en   = (kind == k_dispatch);
		dispatch_dest = dest;
		cdb_valid     = (kind == k_complete);
		cdb_tag       = tag;
		flush         = (kind == k_flush);
		#4;
		exp_retire = 1'b0;
		if (kind != k_flush && rob_m.size() > 0) begin
			exp_retire = rob_m[0].done; // Only a finished head leaves
		end
		check("dispatch_ready", dispatch_ready, rob_m.size() < rob_depth && free_m.size() > 0);
		check("rob_free_entries", rob_free_entries, rob_depth - rob_m.size());
		check("free_count", free_count, free_m.size());
		check("retire_valid", retire_valid, exp_retire);
		if (exp_retire) begin
			check("retire.dest", retire.dest, rob_m[0].dest);
			check("retire.t_new", retire.t_new, rob_m[0].t_new);
			check("retire.t_old", retire.t_old, rob_m[0].t_old);
		end
		exp_new = '0;
		exp_old = '0;
		if (kind == k_dispatch) begin
			exp_new = free_m[0];
			exp_old = spec_m[dest];
			check("rename.t_new", rename.t_new, exp_new);
			check("rename.t_old", rename.t_old, exp_old);
		end
		last_new = exp_new;
		if (kind == k_flush) begin
			// Squashed tags go back in front with the oldest first
			for (int i = rob_m.size() - 1; i >= 0; i--) begin
				free_m.push_front(rob_m[i].t_new);
			end
			rob_m.delete();
			spec_m = arch_m;
		end else begin
			if (exp_retire) begin
				head = rob_m.pop_front();
				arch_m[head.dest] = head.t_new;
				free_m.push_back(head.t_old);
			end
			if (kind == k_complete) begin
				for (int i = 0; i < rob_m.size(); i++) begin
					if (rob_m[i].t_new == tag) begin
						rob_m[i].done = 1'b1;
					end
				end
			end
			if (kind == k_dispatch) begin
				void'(free_m.pop_front());
				spec_m[dest] = exp_new;
				rob_m.push_back('{done: 1'b0, dest: dest, t_new: exp_new, t_old: exp_old});
			end
		end
	endtask

	initial begin
		int         n;
		int         i;
		int         pick;
		int         dispatch_count;
		int         open_rows [$];
		logic [3:0] r;
		vector_t    v;
		phys_tag_t  tag;
		arch_reg_t  dest;
		logic [1:0] kind;
		clock          = 1'b0;
		rst            = 1'b1;
		dispatch_en    = 1'b0;
		dispatch_dest  = '0;
		cdb_valid      = 1'b0;
		cdb_tag        = '0;
		flush          = 1'b0;
		lfsr           = 16'd18;
		errors         = 0;
		checks         = 0;
		dispatch_count = 0;
		model_reset();
		repeat (4) @(posedge clock);
		#1;
		rst = 1'b0;

		for (n = 0; n < n_vectors; n++) begin
			v   = vectors[n];
			tag = (v.kind == k_complete) ? seq_tag[v.seq[5:0]] : '0;
			run_cycle(v.kind, v.dest, tag);
			if (v.kind == k_dispatch) begin
				seq_tag[dispatch_count] = last_new; // Tag of this sequence number
				dispatch_count++;
			end
		end

		for (n = 0; n < n_random; n++) begin
			r    = 4'(lfsr_bits(4));
			dest = arch_reg_t'(lfsr_bits(5));
			tag  = '0;
			kind = k_idle;
			open_rows.delete();
			for (i = 0; i < rob_m.size(); i++) begin
				if (!rob_m[i].done) begin
					open_rows.push_back(i);
				end
			end
			if (r < 7) begin
				if (rob_m.size() < rob_depth && free_m.size() > 0) begin
					kind = k_dispatch;
				end
			end else if (r < 13) begin
				if (open_rows.size() > 0) begin
					pick = int'(lfsr_bits(4)) % open_rows.size(); // Any unfinished entry
					tag  = rob_m[open_rows[pick]].t_new;
					kind = k_complete;
				end
			end else if (r == 15) begin
				kind = k_flush;
			end
			run_cycle(kind, dest, tag);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#((n_vectors + n_random + 40) * 10);
		$display("Timeout: the run did not reach its end in the expected number of cycles");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+dv
source/rename_pkg.sv
source/free_list.sv
source/map_table.sv
source/reorder_buffer.sv
source/rename_unit.sv
dv/rename_tb.sv
